// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f tb.f \
		--top-module tb_top -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/mem_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_checker import mem_pkg::*; (
  input  wire   clock,
  input  wire   reset,
  input  wire   cmd_valid_i,
  input  wire   cmd_ready_o,
  input  addr_t cmd_addr_i,
  input  wire   cmd_wen_i,
  input  data_t cmd_wdata_i,
  input  strb_t cmd_wstrb_i,
  input  wire   rsp_valid_o,
  input  wire   rsp_ready_i,
  input  data_t rsp_data_o,
  input  wire   rsp_write_o,
  input  wire   rsp_err_o,
  output int    errors_o,
  output int    pending_o
);

  // shadow ram, plus which bytes have ever been written
  data_t shadow_data  [int];
  data_t shadow_known [int];

  data_t exp_data_q  [$];
  data_t exp_known_q [$];
  logic  exp_write_q [$];
  logic  exp_err_q   [$];

  int error_count = 0;
  int pending_count = 0;

  assign errors_o  = error_count;
  assign pending_o = pending_count;

  function automatic void predict_response(input addr_t addr, input logic wen,
                                           input data_t wdata, input strb_t wstrb,
                                           output data_t data, output data_t known,
                                           output logic write, output logic err);
    addr_t offset;
    int    idx;
    data_t word;
    data_t seen;
    offset = addr - MEM_BASE;
    err    = (addr < MEM_BASE) || (offset >= addr_t'(MEM_WORDS * 8));
    idx    = int'(offset >> 3) & (MEM_WORDS - 1);
    write  = wen;
    data   = '0;
    known  = '1;
    if (err) begin
      return;
    end
    word = shadow_data.exists(idx) ? shadow_data[idx] : '0;
    seen = shadow_known.exists(idx) ? shadow_known[idx] : '0;
    if (wen) begin
      for (int b = 0; b < 8; b++) begin
        if (wstrb[b]) begin
          word[8*b +: 8] = wdata[8*b +: 8];
          seen[8*b +: 8] = 8'hff;
        end
      end
      shadow_data[idx]  = word;
      shadow_known[idx] = seen;
    end else begin
      data  = word;
      known = seen;
    end
  endfunction

  task automatic record_command();
    data_t e_data;
    data_t e_known;
    logic  e_write;
    logic  e_err;
    predict_response(cmd_addr_i, cmd_wen_i, cmd_wdata_i, cmd_wstrb_i,
                     e_data, e_known, e_write, e_err);
    exp_data_q.push_back(e_data);
    exp_known_q.push_back(e_known);
    exp_write_q.push_back(e_write);
    exp_err_q.push_back(e_err);
  endtask

  task automatic check_response();
    data_t e_data;
    data_t e_known;
    logic  e_write;
    logic  e_err;
    if (exp_data_q.size() == 0) begin
      $display("response arrived while no command was pending");
      error_count++;
      return;
    end
    e_data  = exp_data_q.pop_front();
    e_known = exp_known_q.pop_front();
    e_write = exp_write_q.pop_front();
    e_err   = exp_err_q.pop_front();
    // bytes never written are undefined, only known bytes compare
    if (((rsp_data_o ^ e_data) & e_known) !== '0) begin
      $display("[FAIL] rsp_data_o: got %h expected %h known %h", rsp_data_o, e_data, e_known);
      error_count++;
    end
    if (rsp_write_o !== e_write) begin
      $display("[FAIL] rsp_write_o: got %h expected %h", rsp_write_o, e_write);
      error_count++;
    end
    if (rsp_err_o !== e_err) begin
      $display("[FAIL] rsp_err_o: got %h expected %h", rsp_err_o, e_err);
      error_count++;
    end
  endtask

  // handshakes are stable at the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      if (rsp_valid_o && rsp_ready_i) begin
        check_response();
      end
      if (cmd_valid_i && cmd_ready_o) begin
        record_command();
      end
      pending_count = exp_data_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== bench/mem_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_sva import mem_pkg::*; (
  input  wire   clock,
  input  wire   reset,
  input  wire   cmd_valid_i,
  input  wire   cmd_ready_o,
  input  wire   rsp_valid_o,
  input  wire   rsp_ready_i,
  input  data_t rsp_data_o,
  input  wire   rsp_write_o,
  input  wire   rsp_err_o
);

  int outstanding;
  int reset_fails = 0;
  int stable_fails = 0;
  int order_fails = 0;
  int fail_count;

  assign fail_count = reset_fails + stable_fails + order_fails;

  // accepted commands not yet answered
  always_ff @(posedge clock) begin
    if (reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(cmd_valid_i && cmd_ready_o)
                     - int'(rsp_valid_o && rsp_ready_i);
    end
  end

  rsp_low_after_reset: assert property (@(posedge clock) reset |=> !rsp_valid_o)
    else begin
      $error("rsp_valid_o high in the cycle after reset");
      reset_fails++;
    end

  rsp_held_while_stalled: assert property (@(posedge clock) disable iff (reset)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_data_o)
                                       && $stable(rsp_write_o) && $stable(rsp_err_o)))
    else begin
      $error("response changed or dropped while stalled");
      stable_fails++;
    end

  rsp_after_command: assert property (@(posedge clock) disable iff (reset)
    rsp_valid_o |-> (outstanding > 0))
    else begin
      $error("response without an earlier accepted command");
      order_fails++;
    end

endmodule

bind sim_mem_top mem_sva u_sva (
  .clock       (clock),
  .reset       (reset),
  .cmd_valid_i (cmd_valid_i),
  .cmd_ready_o (cmd_ready_o),
  .rsp_valid_o (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_data_o  (rsp_data_o),
  .rsp_write_o (rsp_write_o),
  .rsp_err_o   (rsp_err_o)
);

`default_nettype wire

// ==== bench/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top import mem_pkg::*; ();

  // about 600 commands at up to 30 cycles each under long stalls
  localparam int TIMEOUT_CYCLES = 20000;
  // six commands in flight, each may wait out a 47 cycle stall
  localparam int DRAIN_CYCLES = 1000;
  localparam int FULL_WORDS = 16;
  localparam int PART_WRITES = 32;
  localparam int MIX_CMDS = 250;
  localparam addr_t WIN_END = MEM_BASE + addr_t'(MEM_WORDS * 8);

  logic  clock = 1'b0;
  logic  reset;
  logic  cmd_valid_i;
  logic  cmd_ready_o;
  addr_t cmd_addr_i;
  logic  cmd_wen_i;
  data_t cmd_wdata_i;
  strb_t cmd_wstrb_i;
  logic  rsp_valid_o;
  logic  rsp_ready_i = 1'b1;
  data_t rsp_data_o;
  logic  rsp_write_o;
  logic  rsp_err_o;

  integer seed = 96;
  integer ready_seed = 97;
  int     ready_mode = 0;
  int     ready_rand;
  int     stall_left = 0;
  int     cycles = 0;
  int     stall_seen = 0;
  int     bench_errors = 0;
  int     checker_errors;
  int     pending;
  int     written_idx [FULL_WORDS];

  sim_mem_top u_dut (.*);

  mem_checker u_checker (.*, .errors_o(checker_errors), .pending_o(pending));

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d responses pending", cycles, pending);
      $display("Test failed");
      $finish;
    end
  end

  // ready_mode 0 keeps ready high, 1 toggles it randomly and 2 adds long stalls
  always @(posedge clock) begin
    #1;
    if (ready_mode == 0) begin
      rsp_ready_i = 1'b1;
    end else if (ready_mode == 1) begin
      ready_rand  = $random(ready_seed);
      rsp_ready_i = ready_rand[0];
    end else if (stall_left > 0) begin
      rsp_ready_i = 1'b0;
      stall_left--;
    end else begin
      ready_rand  = $random(ready_seed);
      rsp_ready_i = 1'b1;
      if ((ready_rand & 7) == 0) begin
        stall_left = 16 + ((ready_rand >>> 3) & 31);
      end
    end
  end

  always @(negedge clock) begin
    if (!reset && cmd_valid_i && !cmd_ready_o) begin
      stall_seen++;
    end
  end

  function automatic addr_t word_addr(input int idx);
    return MEM_BASE + (addr_t'(idx) << 3);
  endfunction

  // starts 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_cmd(input addr_t addr, input logic wen, input data_t wdata,
                          input strb_t wstrb);
    logic taken;
    cmd_valid_i = 1'b1;
    cmd_addr_i  = addr;
    cmd_wen_i   = wen;
    cmd_wdata_i = wdata;
    cmd_wstrb_i = wstrb;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clock);
      taken = cmd_ready_o;
      @(posedge clock);
      #1;
    end
    cmd_valid_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (pending != 0 && waited < DRAIN_CYCLES) begin
      @(posedge clock);
      #1;
      waited++;
    end
  endtask

  task automatic run_mix(input int n);
    int    r;
    addr_t addr;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      if ((r & 31) == 0) begin
        addr = r[5] ? WIN_END + addr_t'((r >>> 6) & 511)
                    : MEM_BASE - 64'd8 - addr_t'((r >>> 6) & 511);
      end else begin
        // low three bits must be ignored
        addr = word_addr((r >>> 6) & 127) + addr_t'((r >>> 13) & 7);
      end
      send_cmd(addr, r[16], {$random(seed), $random(seed)}, strb_t'($random(seed)));
      if (((r >>> 17) & 3) == 0) begin
        idle_cycles(1 + ((r >>> 19) & 3));
      end
    end
  endtask

  initial begin
    int    pick;
    int    total;
    addr_t bad_addr [6];
    reset       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_addr_i  = '0;
    cmd_wen_i   = 1'b0;
    cmd_wdata_i = '0;
    cmd_wstrb_i = '0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    if (cmd_ready_o !== 1'b1) begin
      $display("[FAIL] cmd_ready_o after reset: got %h expected 1", cmd_ready_o);
      bench_errors++;
    end
    if (rsp_valid_o !== 1'b0) begin
      $display("[FAIL] rsp_valid_o after reset: got %h expected 0", rsp_valid_o);
      bench_errors++;
    end

    for (int i = 0; i < FULL_WORDS; i++) begin
      written_idx[i] = $random(seed) & (MEM_WORDS - 1);
      send_cmd(word_addr(written_idx[i]), 1'b1, {$random(seed), $random(seed)}, 8'hff);
    end
    for (int i = 0; i < FULL_WORDS; i++) begin
      send_cmd(word_addr(written_idx[i]), 1'b0, '0, '0);
    end

    ready_mode = 1;
    for (int i = 0; i < PART_WRITES; i++) begin
      pick = written_idx[$unsigned($random(seed)) % FULL_WORDS];
      send_cmd(word_addr(pick), 1'b1, {$random(seed), $random(seed)}, strb_t'($random(seed)));
      send_cmd(word_addr(pick), 1'b0, '0, '0);
    end

    // two of these alias onto written words through bits 12 to 3
    bad_addr[0] = MEM_BASE - 64'd8;
    bad_addr[1] = MEM_BASE - 64'd1;
    bad_addr[2] = MEM_BASE - 64'd8192 + (addr_t'(written_idx[1]) << 3);
    bad_addr[3] = WIN_END;
    bad_addr[4] = WIN_END + (addr_t'(written_idx[0]) << 3);
    bad_addr[5] = 64'hffff_ffff_ffff_fff8;
    for (int k = 0; k < 6; k++) begin
      send_cmd(bad_addr[k], 1'b1, 64'hdead_beef_0bad_f00d, 8'hff);
      send_cmd(bad_addr[k], 1'b0, '0, '0);
    end
    for (int i = 0; i < FULL_WORDS; i++) begin
      send_cmd(word_addr(written_idx[i]), 1'b0, '0, '0);
    end

    run_mix(MIX_CMDS);
    ready_mode = 2;
    run_mix(MIX_CMDS);
    wait_drained();
    idle_cycles(4);

    if (stall_seen == 0) begin
      $display("cmd_ready_o never dropped while a command was waiting");
      bench_errors++;
    end
    if (pending != 0) begin
      $display("%0d responses never arrived", pending);
      bench_errors++;
    end
    total = checker_errors + bench_errors + u_dut.u_sva.fail_count;
    $display("errors: checker %0d, bench %0d, assertions %0d",
             checker_errors, bench_errors, u_dut.u_sva.fail_count);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder import mem_pkg::*; (
  input  wire       clock,
  input  wire       reset,

  // core command channel
  input  wire       cmd_valid_i,
  output logic      cmd_ready_o,
  input  addr_t     cmd_addr_i,
  input  wire       cmd_wen_i,
  input  data_t     cmd_wdata_i,
  input  strb_t     cmd_wstrb_i,

  // decoded entry towards the fifo
  output logic      dec_valid_o,
  input  wire       dec_ready_i,
  output word_idx_t dec_idx_o,
  output logic      dec_wen_o,
  output data_t     dec_wdata_o,
  output data_t     dec_mask_o,
  output logic      dec_err_o
);

  addr_t     offset;
  logic      in_range;
  word_idx_t idx;
  data_t     mask;
  logic      accept;

  // offset from the window base, index from bits 12 to 3
  always_comb begin
    offset   = cmd_addr_i - MEM_BASE;
    in_range = (cmd_addr_i >= MEM_BASE) && (offset < MEM_BYTES);
    idx      = offset[WORD_IDX_W+2:3];
  end

  // one strobe bit covers one byte lane
  always_comb begin
    for (int b = 0; b < STRB_W; b++) begin
      mask[8*b +: 8] = {8{cmd_wstrb_i[b]}};
    end
  end

  // entry may refill in the cycle it drains
  assign cmd_ready_o = !dec_valid_o || dec_ready_i;
  assign accept      = cmd_valid_i && cmd_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid_o <= 1'b0;
    end else if (accept) begin
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      dec_idx_o   <= in_range ? idx : '0;
      dec_wen_o   <= cmd_wen_i;
      dec_wdata_o <= cmd_wdata_i;
      // out of range entries must never touch the array
      dec_mask_o  <= in_range ? mask : '0;
      dec_err_o   <= !in_range;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cmd_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_fifo import mem_pkg::*; (
  input  wire       clock,
  input  wire       reset,

  input  wire       push_valid_i,
  output logic      push_ready_o,
  input  word_idx_t push_idx_i,
  input  wire       push_wen_i,
  input  data_t     push_wdata_i,
  input  data_t     push_mask_i,
  input  wire       push_err_i,

  output logic      pop_valid_o,
  input  wire       pop_ready_i,
  output word_idx_t pop_idx_o,
  output logic      pop_wen_o,
  output data_t     pop_wdata_o,
  output data_t     pop_mask_o,
  output logic      pop_err_o
);

  word_idx_t idx_q   [FIFO_DEPTH];
  logic      wen_q   [FIFO_DEPTH];
  data_t     wdata_q [FIFO_DEPTH];
  data_t     mask_q  [FIFO_DEPTH];
  logic      err_q   [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  push;
  logic                  pop;

  function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // full queue still takes a push when the head leaves
  assign push_ready_o = (count != FIFO_CNT_W'(FIFO_DEPTH)) || pop_ready_i;
  assign pop_valid_o  = (count != '0);
  assign push         = push_valid_i && push_ready_o;
  assign pop          = pop_valid_o && pop_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      idx_q[wr_ptr]   <= push_idx_i;
      wen_q[wr_ptr]   <= push_wen_i;
      wdata_q[wr_ptr] <= push_wdata_i;
      mask_q[wr_ptr]  <= push_mask_i;
      err_q[wr_ptr]   <= push_err_i;
    end
  end

  assign pop_idx_o   = idx_q[rd_ptr];
  assign pop_wen_o   = wen_q[rd_ptr];
  assign pop_wdata_o = wdata_q[rd_ptr];
  assign pop_mask_o  = mask_q[rd_ptr];
  assign pop_err_o   = err_q[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // bus widths
  localparam int ADDR_W = 64;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // ram window, same start as the core reset pc
  localparam addr_t MEM_BASE = 64'h0000_0000_8000_0000;

  // 1024 words of 64 bits
  localparam int MEM_WORDS = 1024;
  localparam int WORD_IDX_W = $clog2(MEM_WORDS);

  // window size in bytes, for the range check
  localparam addr_t MEM_BYTES = 64'(MEM_WORDS * STRB_W);

  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  // command queue between decoder and ram port
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

endpackage

`default_nettype wire

// ==== logic/ram_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module ram_port import mem_pkg::*; (
  input  wire       clock,
  input  wire       reset,

  // head of the command queue
  input  wire       q_valid_i,
  output logic      q_ready_o,
  input  word_idx_t q_idx_i,
  input  wire       q_wen_i,
  input  data_t     q_wdata_i,
  input  data_t     q_mask_i,
  input  wire       q_err_i,

  // response channel
  output logic      rsp_valid_o,
  input  wire       rsp_ready_i,
  output data_t     rsp_data_o,
  output logic      rsp_write_o,
  output logic      rsp_err_o
);

  typedef enum logic {
    ST_IDLE,
    ST_HOLD
  } state_t;

  data_t  mem [MEM_WORDS];
  state_t state;
  logic   pop;
  logic   do_write;
  data_t  cur_word;
  data_t  merged;

  // one command in execution, queue stalls while a response waits
  assign q_ready_o   = (state == ST_IDLE);
  assign rsp_valid_o = (state == ST_HOLD);
  assign pop         = q_valid_i && q_ready_o;
  assign do_write    = pop && q_wen_i && !q_err_i;

  assign cur_word = mem[q_idx_i];
  // keep old bytes where the mask is clear
  assign merged   = (cur_word & ~q_mask_i) | (q_wdata_i & q_mask_i);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (pop) begin
            state <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (rsp_ready_i) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_write) begin
      mem[q_idx_i] <= merged;
    end
  end

  // response payload, only loaded on a pop so it holds while stalled
  always_ff @(posedge clock) begin
    if (pop) begin
      rsp_write_o <= q_wen_i;
      rsp_err_o   <= q_err_i;
      if (q_err_i || q_wen_i) begin
        rsp_data_o <= '0;
      end else begin
        rsp_data_o <= cur_word;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/sim_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sim_mem_top import mem_pkg::*; (
  input  wire   clock,
  input  wire   reset,

  input  wire   cmd_valid_i,
  output logic  cmd_ready_o,
  input  addr_t cmd_addr_i,
  input  wire   cmd_wen_i,
  input  data_t cmd_wdata_i,
  input  strb_t cmd_wstrb_i,

  output logic  rsp_valid_o,
  input  wire   rsp_ready_i,
  output data_t rsp_data_o,
  output logic  rsp_write_o,
  output logic  rsp_err_o
);

  // decoder to fifo
  logic      dec_valid;
  logic      dec_ready;
  word_idx_t dec_idx;
  logic      dec_wen;
  data_t     dec_wdata;
  data_t     dec_mask;
  logic      dec_err;

  // fifo to ram port
  logic      q_valid;
  logic      q_ready;
  word_idx_t q_idx;
  logic      q_wen;
  data_t     q_wdata;
  data_t     q_mask;
  logic      q_err;

  cmd_decoder u_decoder (
    .clock       (clock),
    .reset       (reset),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wen_i   (cmd_wen_i),
    .cmd_wdata_i (cmd_wdata_i),
    .cmd_wstrb_i (cmd_wstrb_i),
    .dec_valid_o (dec_valid),
    .dec_ready_i (dec_ready),
    .dec_idx_o   (dec_idx),
    .dec_wen_o   (dec_wen),
    .dec_wdata_o (dec_wdata),
    .dec_mask_o  (dec_mask),
    .dec_err_o   (dec_err)
  );

  cmd_fifo u_fifo (
    .clock        (clock),
    .reset        (reset),
    .push_valid_i (dec_valid),
    .push_ready_o (dec_ready),
    .push_idx_i   (dec_idx),
    .push_wen_i   (dec_wen),
    .push_wdata_i (dec_wdata),
    .push_mask_i  (dec_mask),
    .push_err_i   (dec_err),
    .pop_valid_o  (q_valid),
    .pop_ready_i  (q_ready),
    .pop_idx_o    (q_idx),
    .pop_wen_o    (q_wen),
    .pop_wdata_o  (q_wdata),
    .pop_mask_o   (q_mask),
    .pop_err_o    (q_err)
  );

  ram_port u_ram_port (
    .clock       (clock),
    .reset       (reset),
    .q_valid_i   (q_valid),
    .q_ready_o   (q_ready),
    .q_idx_i     (q_idx),
    .q_wen_i     (q_wen),
    .q_wdata_i   (q_wdata),
    .q_mask_i    (q_mask),
    .q_err_i     (q_err),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o),
    .rsp_write_o (rsp_write_o),
    .rsp_err_o   (rsp_err_o)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
logic/mem_pkg.sv
logic/cmd_decoder.sv
logic/cmd_fifo.sv
logic/ram_port.sv
logic/sim_mem_top.sv
bench/mem_sva.sv
bench/mem_checker.sv
bench/tb_top.sv
